// ==== rtl/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

  // Word and address width
  localparam int xlen = 32;

  // Architectural registers including x0
  localparam int reg_count = 32;

  localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

  // Major opcodes of the supported RV32I subset
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111
  } opcode_t;

  // PASS_B forwards operand b for LUI
  typedef enum logic [3:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    SLT,
    SLL,
    SRL,
    PASS_B
  } alu_op_t;

  // Sequencer states
  typedef enum logic [1:0] {
    FETCH,
    EXECUTE,
    MEMORY,
    WRITEBACK
  } state_t;

endpackage

`default_nettype wire

// ==== rtl/decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module decoder import cpu_pkg::*; (
  input  logic [31:0] instr,
  output logic [4:0]  rs1,
  output logic [4:0]  rs2,
  output logic [4:0]  rd,
  output logic [31:0] imm,
  output alu_op_t     alu_op,
  output logic        use_imm,
  output logic        reg_write,
  output logic        is_load,
  output logic        is_store,
  output logic        is_branch,
  output logic        branch_ne,
  output logic        is_jal,
  output logic        illegal
);

  opcode_t opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_s;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_u;
  logic [xlen-1:0] imm_j;

  assign opcode = opcode_t'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign rs1 = instr[19:15];
  assign rs2 = instr[24:20];
  assign rd  = instr[11:7];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    alu_op    = ADD;
    imm       = imm_i;
    use_imm   = 1'b0;
    reg_write = 1'b0;
    is_load   = 1'b0;
    is_store  = 1'b0;
    is_branch = 1'b0;
    branch_ne = 1'b0;
    is_jal    = 1'b0;
    illegal   = 1'b0;
    case (opcode)
      OP: begin
        reg_write = 1'b1;
        case (funct3)
          3'b000:  alu_op = funct7[5] ? SUB : ADD;
          3'b001:  alu_op = SLL;
          3'b010:  alu_op = SLT;
          3'b100:  alu_op = XOR;
          3'b101:  alu_op = SRL;
          3'b110:  alu_op = OR;
          3'b111:  alu_op = AND;
          default: illegal = 1'b1;
        endcase
        // Only SUB may carry funct7 bit 5
        if (funct7 != 7'b0000000 && !(funct7 == 7'b0100000 && funct3 == 3'b000)) begin
          illegal = 1'b1;
        end
      end
      OP_IMM: begin
        reg_write = 1'b1;
        use_imm   = 1'b1;
        case (funct3)
          3'b000:  alu_op = ADD;
          3'b100:  alu_op = XOR;
          3'b110:  alu_op = OR;
          3'b111:  alu_op = AND;
          default: illegal = 1'b1;
        endcase
      end
      LUI: begin
        alu_op    = PASS_B;
        imm       = imm_u;
        use_imm   = 1'b1;
        reg_write = 1'b1;
      end
      LOAD: begin
        use_imm   = 1'b1;
        reg_write = 1'b1;
        is_load   = 1'b1;
        illegal   = funct3 != 3'b010;
      end
      STORE: begin
        imm      = imm_s;
        use_imm  = 1'b1;
        is_store = 1'b1;
        illegal  = funct3 != 3'b010;
      end
      BRANCH: begin
        alu_op    = SUB;
        imm       = imm_b;
        is_branch = 1'b1;
        branch_ne = funct3[0];
        illegal   = funct3[2:1] != 2'b00;
      end
      JAL: begin
        imm       = imm_j;
        reg_write = 1'b1;
        is_jal    = 1'b1;
      end
      default: illegal = 1'b1;
    endcase
    // Unknown encodings fall through as a no-op
    if (illegal) begin
      reg_write = 1'b0;
      is_load   = 1'b0;
      is_store  = 1'b0;
      is_branch = 1'b0;
      is_jal    = 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu import cpu_pkg::*; (
  input  alu_op_t     op,
  input  logic [31:0] a,
  input  logic [31:0] b,
  output logic [31:0] result,
  output logic        zero
);

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (op)
      ADD:     result = a + b;
      SUB:     result = a - b;
      AND:     result = a & b;
      OR:      result = a | b;
      XOR:     result = a ^ b;
      SLT:     result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
      SLL:     result = a << shamt;
      SRL:     result = a >> shamt;
      PASS_B:  result = b;
      default: result = '0;
    endcase
  end

  // Equality for branches via SUB
  assign zero = result == '0;

endmodule

`default_nettype wire

// ==== rtl/register.sv ====
`timescale 1ns/1ps
`default_nettype none

module register import cpu_pkg::*; (
  input  logic        clock,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  output logic [31:0] rs1_data,
  output logic [31:0] rs2_data,
  input  logic        we,
  input  logic [4:0]  waddr,
  input  logic [31:0] wdata
);

  logic [xlen-1:0] regs [reg_count];

  always_ff @(posedge clock) begin
    if (we && waddr != 5'd0) begin
      regs[waddr] <= wdata;
    end
  end

  // x0 reads as zero
  assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== rtl/control_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module control_unit import cpu_pkg::*; (
  input  logic        clock,
  input  logic        rst,
  output logic        imemory_valid,
  output logic [31:0] imemory_addr,
  input  logic [31:0] imemory_rdata,
  input  logic        imemory_ready,
  output logic        dmemory_valid,
  output logic [31:0] dmemory_addr,
  output logic [31:0] dmemory_wdata,
  output logic [3:0]  dmemory_wstrb,
  input  logic [31:0] dmemory_rdata,
  input  logic        dmemory_ready,
  output logic [31:0] instr,
  input  logic [4:0]  rd,
  input  logic [31:0] imm,
  input  alu_op_t     alu_op,
  input  logic        use_imm,
  input  logic        reg_write,
  input  logic        is_load,
  input  logic        is_store,
  input  logic        is_branch,
  input  logic        branch_ne,
  input  logic        is_jal,
  input  logic        illegal,
  input  logic [31:0] rs1_data,
  input  logic [31:0] rs2_data,
  output logic [31:0] alu_a,
  output logic [31:0] alu_b,
  input  logic [31:0] alu_result,
  input  logic        alu_zero,
  output logic        we,
  output logic [4:0]  waddr,
  output logic [31:0] wdata
);

  state_t state;
  logic [xlen-1:0] pc;
  logic [xlen-1:0] ir;
  logic [xlen-1:0] result_q;
  logic [xlen-1:0] load_q;
  logic [xlen-1:0] pc_plus4;
  logic [xlen-1:0] pc_next;
  logic mem_access;
  logic taken;

  assign alu_a = rs1_data;
  assign alu_b = use_imm ? imm : rs2_data;

  assign mem_access = (is_load || is_store) && !illegal;
  // Operands stay stable from EXECUTE to WRITEBACK, so zero is still valid there
  assign taken = is_branch && alu_op == SUB && (alu_zero != branch_ne);

  assign pc_plus4 = pc + 32'd4;
  assign pc_next = (taken || is_jal) ? pc + imm : pc_plus4;

  always_ff @(posedge clock) begin
    if (rst) begin
      state <= FETCH;
      pc <= reset_pc;
      imemory_valid <= 1'b0;
      dmemory_valid <= 1'b0;
    end else begin
      case (state)
        FETCH: begin
          if (!imemory_valid) begin
            imemory_valid <= 1'b1;
          end else if (imemory_ready) begin
            imemory_valid <= 1'b0;
            state <= EXECUTE;
          end
        end
        EXECUTE: begin
          if (mem_access) begin
            dmemory_valid <= 1'b1;
            state <= MEMORY;
          end else begin
            state <= WRITEBACK;
          end
        end
        MEMORY: begin
          if (dmemory_ready) begin
            dmemory_valid <= 1'b0;
            state <= WRITEBACK;
          end
        end
        WRITEBACK: begin
          pc <= pc_next;
          imemory_valid <= 1'b1;
          state <= FETCH;
        end
        default: state <= FETCH;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == FETCH && imemory_valid && imemory_ready) begin
      ir <= imemory_rdata;
    end
    if (state == EXECUTE) begin
      result_q <= alu_result;
    end
    if (state == MEMORY && dmemory_ready) begin
      load_q <= dmemory_rdata;
    end
  end

  assign instr = ir;
  assign imemory_addr = pc;

  // Address latched in EXECUTE holds for the whole request
  assign dmemory_addr = result_q;
  assign dmemory_wdata = rs2_data;
  assign dmemory_wstrb = is_store ? 4'b1111 : 4'b0000;

  assign we = state == WRITEBACK && reg_write && !illegal && rd != 5'd0;
  assign waddr = rd;

  always_comb begin
    if (is_jal) begin
      wdata = pc_plus4;
    end else if (is_load) begin
      wdata = load_q;
    end else begin
      wdata = result_q;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu import cpu_pkg::*; (
  input  logic        clock,
  input  logic        rst,
  output logic        imemory_valid,
  output logic [31:0] imemory_addr,
  input  logic [31:0] imemory_rdata,
  input  logic        imemory_ready,
  output logic        dmemory_valid,
  output logic [31:0] dmemory_addr,
  output logic [31:0] dmemory_wdata,
  output logic [3:0]  dmemory_wstrb,
  input  logic [31:0] dmemory_rdata,
  input  logic        dmemory_ready
);

  logic [xlen-1:0] instr;
  logic [4:0] rs1;
  logic [4:0] rs2;
  logic [4:0] rd;
  logic [xlen-1:0] imm;
  alu_op_t alu_op;
  logic use_imm;
  logic reg_write;
  logic is_load;
  logic is_store;
  logic is_branch;
  logic branch_ne;
  logic is_jal;
  logic illegal;
  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;
  logic [xlen-1:0] alu_a;
  logic [xlen-1:0] alu_b;
  logic [xlen-1:0] alu_result;
  logic alu_zero;
  logic we;
  logic [4:0] waddr;
  logic [xlen-1:0] wdata;

  control_unit control_unit_comp (
    .clock         (clock),
    .rst           (rst),
    .imemory_valid (imemory_valid),
    .imemory_addr  (imemory_addr),
    .imemory_rdata (imemory_rdata),
    .imemory_ready (imemory_ready),
    .dmemory_valid (dmemory_valid),
    .dmemory_addr  (dmemory_addr),
    .dmemory_wdata (dmemory_wdata),
    .dmemory_wstrb (dmemory_wstrb),
    .dmemory_rdata (dmemory_rdata),
    .dmemory_ready (dmemory_ready),
    .instr         (instr),
    .rd            (rd),
    .imm           (imm),
    .alu_op        (alu_op),
    .use_imm       (use_imm),
    .reg_write     (reg_write),
    .is_load       (is_load),
    .is_store      (is_store),
    .is_branch     (is_branch),
    .branch_ne     (branch_ne),
    .is_jal        (is_jal),
    .illegal       (illegal),
    .rs1_data      (rs1_data),
    .rs2_data      (rs2_data),
    .alu_a         (alu_a),
    .alu_b         (alu_b),
    .alu_result    (alu_result),
    .alu_zero      (alu_zero),
    .we            (we),
    .waddr         (waddr),
    .wdata         (wdata)
  );

  decoder decoder_comp (
    .instr     (instr),
    .rs1       (rs1),
    .rs2       (rs2),
    .rd        (rd),
    .imm       (imm),
    .alu_op    (alu_op),
    .use_imm   (use_imm),
    .reg_write (reg_write),
    .is_load   (is_load),
    .is_store  (is_store),
    .is_branch (is_branch),
    .branch_ne (branch_ne),
    .is_jal    (is_jal),
    .illegal   (illegal)
  );

  alu alu_comp (
    .op     (alu_op),
    .a      (alu_a),
    .b      (alu_b),
    .result (alu_result),
    .zero   (alu_zero)
  );

  register register_comp (
    .clock    (clock),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (we),
    .waddr    (waddr),
    .wdata    (wdata)
  );

endmodule

`default_nettype wire

// ==== verif/cpu_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_asserts import cpu_pkg::*; (
  input logic        clock,
  input logic        rst,
  input logic        imemory_valid,
  input logic [31:0] imemory_addr,
  input logic        imemory_ready,
  input logic        dmemory_valid,
  input logic [31:0] dmemory_addr,
  input logic [31:0] dmemory_wdata,
  input logic [3:0]  dmemory_wstrb,
  input logic        dmemory_ready,
  input state_t      state
);

  // Requests hold until ready
  fetch_hold: assert property (@(posedge clock) disable iff (rst)
    imemory_valid && !imemory_ready |=> imemory_valid && $stable(imemory_addr))
    else $error("instruction request dropped or changed before imemory_ready");

  data_hold: assert property (@(posedge clock) disable iff (rst)
    dmemory_valid && !dmemory_ready |=> dmemory_valid && $stable(dmemory_addr)
      && $stable(dmemory_wdata) && $stable(dmemory_wstrb))
    else $error("data request dropped or changed before dmemory_ready");

  one_port: assert property (@(posedge clock) disable iff (rst)
    !(imemory_valid && dmemory_valid))
    else $error("both memory ports requested in the same cycle");

  data_in_memory: assert property (@(posedge clock) disable iff (rst)
    dmemory_valid |-> state == MEMORY)
    else $error("data request outside the MEMORY state");

  reset_quiet: assert property (@(posedge clock)
    $fell(rst) |-> !imemory_valid && !dmemory_valid)
    else $error("memory request in the first cycle after reset");

endmodule

bind cpu cpu_asserts i_asserts (
  .clock         (clock),
  .rst           (rst),
  .imemory_valid (imemory_valid),
  .imemory_addr  (imemory_addr),
  .imemory_ready (imemory_ready),
  .dmemory_valid (dmemory_valid),
  .dmemory_addr  (dmemory_addr),
  .dmemory_wdata (dmemory_wdata),
  .dmemory_wstrb (dmemory_wstrb),
  .dmemory_ready (dmemory_ready),
  .state         (control_unit_comp.state)
);

`default_nettype wire

// ==== verif/cpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_tb import cpu_pkg::*; ();

  localparam int mem_words = 1024;

  logic clock = 1'b0;
  logic rst = 1'b1;
  logic imemory_valid;
  logic [31:0] imemory_addr;
  logic [31:0] imemory_rdata = '0;
  logic imemory_ready = 1'b0;
  logic dmemory_valid;
  logic [31:0] dmemory_addr;
  logic [31:0] dmemory_wdata;
  logic [3:0] dmemory_wstrb;
  logic [31:0] dmemory_rdata = '0;
  logic dmemory_ready = 1'b0;

  logic [31:0] mem [mem_words];
  logic [31:0] model_mem [mem_words];
  logic [31:0] model_regs [32];
  logic [31:0] model_pc;
  logic [31:0] halt_pc;
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  logic [1:0] wait_table [256];
  logic [31:0] lfsr;
  logic [1:0] iwait;
  logic [1:0] dwait;
  logic [7:0] iidx;
  logic [7:0] didx;
  int prog_len;
  int store_off;
  int timeout_limit;
  int cycle_count;
  int halt_fetches;

  always #50 clock = ~clock;

  cpu i_dut (
    .clock         (clock),
    .rst           (rst),
    .imemory_valid (imemory_valid),
    .imemory_addr  (imemory_addr),
    .imemory_rdata (imemory_rdata),
    .imemory_ready (imemory_ready),
    .dmemory_valid (dmemory_valid),
    .dmemory_addr  (dmemory_addr),
    .dmemory_wdata (dmemory_wdata),
    .dmemory_wstrb (dmemory_wstrb),
    .dmemory_rdata (dmemory_rdata),
    .dmemory_ready (dmemory_ready)
  );

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // Instruction encoders
  function automatic logic [31:0] r_type(input logic [2:0] f3, input logic [6:0] f7,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(input logic [6:0] op, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_type(input logic [4:0] rs1, input logic [4:0] rs2,
                                         input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] u_type(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  task automatic emit(input logic [31:0] w);
    mem[prog_len] = w;
    prog_len++;
  endtask

  // Data area starts at x9 = 0x400
  task automatic store_reg(input logic [4:0] rs);
    emit(s_type(5'd9, rs, 12'(store_off)));
    store_off += 4;
  endtask

  task automatic reg_op(input logic [2:0] f3, input logic [6:0] f7);
    logic [31:0] a;
    logic [31:0] b;
    take_bits(3, a);
    take_bits(3, b);
    emit(r_type(f3, f7, 5'd10, 5'(a[2:0]) + 5'd1, 5'(b[2:0]) + 5'd1));
    store_reg(5'd10);
  endtask

  task automatic imm_op(input logic [2:0] f3);
    logic [31:0] a;
    logic [31:0] v;
    take_bits(3, a);
    take_bits(12, v);
    emit(i_type(7'b0010011, f3, 5'd11, 5'(a[2:0]) + 5'd1, v[11:0]));
    store_reg(5'd11);
  endtask

  // ISA model of one instruction that returns 1 for a store
  function automatic logic ref_step(output logic [31:0] st_addr, output logic [31:0] st_data);
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    logic [31:0] addr;
    logic [31:0] npc;
    logic [31:0] immi;
    logic [31:0] imms;
    logic [31:0] immb;
    logic [31:0] immj;
    logic wr;
    logic st;
    ins = model_mem[model_pc[11:2]];
    a = model_regs[ins[19:15]];
    b = model_regs[ins[24:20]];
    immi = {{20{ins[31]}}, ins[31:20]};
    imms = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    immb = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    immj = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
    npc = model_pc + 32'd4;
    r = '0;
    wr = 1'b0;
    st = 1'b0;
    st_addr = '0;
    st_data = '0;
    case (ins[6:0])
      7'b0110011: begin
        wr = 1'b1;
        case (ins[14:12])
          3'b000: r = ins[30] ? a - b : a + b;
          3'b001: r = a << b[4:0];
          3'b010: r = {31'b0, $signed(a) < $signed(b)};
          3'b100: r = a ^ b;
          3'b101: r = a >> b[4:0];
          3'b110: r = a | b;
          default: r = a & b;
        endcase
      end
      7'b0010011: begin
        wr = 1'b1;
        case (ins[14:12])
          3'b000: r = a + immi;
          3'b100: r = a ^ immi;
          3'b110: r = a | immi;
          default: r = a & immi;
        endcase
      end
      7'b0110111: begin
        wr = 1'b1;
        r = {ins[31:12], 12'b0};
      end
      7'b0000011: begin
        wr = 1'b1;
        addr = a + immi;
        r = model_mem[addr[11:2]];
      end
      7'b0100011: begin
        st = 1'b1;
        st_addr = a + imms;
        st_data = b;
        model_mem[st_addr[11:2]] = b;
      end
      7'b1100011: begin
        if ((a == b) != ins[12]) begin
          npc = model_pc + immb;
        end
      end
      default: begin
        wr = 1'b1;
        r = model_pc + 32'd4;
        npc = model_pc + immj;
      end
    endcase
    if (wr && ins[11:7] != 5'd0) begin
      model_regs[ins[11:7]] = r;
    end
    model_pc = npc;
    return st;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error at %0t: %s = %08h, expected %08h", $time, name, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  initial begin
    logic [31:0] v;
    lfsr = 32'h9d00;
    prog_len = 0;
    store_off = 0;
    cycle_count = 0;
    halt_fetches = 0;
    for (int i = 0; i < mem_words; i++) begin
      mem[i] = {~i[15:0], i[15:0]};
    end
    for (int r = 1; r <= 8; r++) begin
      take_bits(20, v);
      emit(u_type(5'(r), v[19:0]));
      take_bits(12, v);
      emit(i_type(7'b0010011, 3'b000, 5'(r), 5'(r), v[11:0]));
    end
    emit(i_type(7'b0010011, 3'b000, 5'd9, 5'd0, 12'h400));
    reg_op(3'b000, 7'h00);
    reg_op(3'b000, 7'h20);
    reg_op(3'b111, 7'h00);
    reg_op(3'b110, 7'h00);
    reg_op(3'b100, 7'h00);
    reg_op(3'b010, 7'h00);
    reg_op(3'b001, 7'h00);
    reg_op(3'b101, 7'h00);
    imm_op(3'b000);
    imm_op(3'b111);
    imm_op(3'b110);
    imm_op(3'b100);
    take_bits(20, v);
    emit(u_type(5'd12, v[19:0]));
    store_reg(5'd12);
    // Load back the first stored result, then try to write x0
    emit(i_type(7'b0000011, 3'b010, 5'd13, 5'd9, 12'd0));
    emit(r_type(3'b000, 7'h00, 5'd13, 5'd13, 5'd1));
    store_reg(5'd13);
    emit(i_type(7'b0010011, 3'b000, 5'd0, 5'd0, 12'd5));
    store_reg(5'd0);
    // Sum 4+3+2+1 in a BNE loop
    emit(i_type(7'b0010011, 3'b000, 5'd14, 5'd0, 12'd4));
    emit(i_type(7'b0010011, 3'b000, 5'd15, 5'd0, 12'd0));
    emit(r_type(3'b000, 7'h00, 5'd15, 5'd15, 5'd14));
    emit(i_type(7'b0010011, 3'b000, 5'd14, 5'd14, 12'hfff));
    emit(b_type(3'b001, 5'd14, 5'd0, 13'h1ff8));
    store_reg(5'd15);
    emit(i_type(7'b0010011, 3'b000, 5'd16, 5'd0, 12'd7));
    emit(b_type(3'b000, 5'd0, 5'd0, 13'd8));
    emit(i_type(7'b0010011, 3'b000, 5'd16, 5'd0, 12'd1));
    emit(b_type(3'b000, 5'd14, 5'd15, 13'd8));
    emit(i_type(7'b0010011, 3'b000, 5'd16, 5'd16, 12'd2));
    emit(b_type(3'b001, 5'd14, 5'd0, 13'd8));
    emit(i_type(7'b0010011, 3'b000, 5'd16, 5'd16, 12'd3));
    store_reg(5'd16);
    emit(j_type(5'd17, 21'd8));
    emit(i_type(7'b0010011, 3'b000, 5'd17, 5'd0, 12'd0));
    store_reg(5'd17);
    halt_pc = 32'(prog_len * 4);
    emit(j_type(5'd0, 21'd0));
    for (int i = 0; i < 256; i++) begin
      take_bits(2, v);
      wait_table[i] = v[1:0];
    end
    model_mem = mem;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    model_pc = reset_pc;
    timeout_limit = 20 * prog_len * 10;
    repeat (8) @(posedge clock);
    rst <= 1'b0;
  end

  // Instruction memory
  always @(posedge clock) begin
    if (rst) begin
      imemory_ready <= 1'b0;
      iwait <= 2'd0;
      iidx <= 8'd0;
    end else begin
      imemory_ready <= 1'b0;
      if (imemory_valid && !imemory_ready) begin
        if (iwait == 2'd0) begin
          imemory_ready <= 1'b1;
          imemory_rdata <= mem[imemory_addr[11:2]];
          iwait <= wait_table[iidx];
          iidx <= iidx + 8'd1;
        end else begin
          iwait <= iwait - 2'd1;
        end
      end
    end
  end

  // Data memory
  always @(posedge clock) begin
    if (rst) begin
      dmemory_ready <= 1'b0;
      dwait <= 2'd1;
      didx <= 8'd128;
    end else begin
      dmemory_ready <= 1'b0;
      if (dmemory_valid && !dmemory_ready) begin
        if (dwait == 2'd0) begin
          dmemory_ready <= 1'b1;
          dmemory_rdata <= mem[dmemory_addr[11:2]];
          if (dmemory_wstrb == 4'b1111) begin
            mem[dmemory_addr[11:2]] <= dmemory_wdata;
          end
          dwait <= wait_table[didx];
          didx <= didx + 8'd1;
        end else begin
          dwait <= dwait - 2'd1;
        end
      end
    end
  end

  always @(posedge clock) begin
    logic is_store;
    logic [31:0] st_addr;
    logic [31:0] st_data;
    if (!rst) begin
      cycle_count = cycle_count + 1;
      if (cycle_count > timeout_limit) begin
        $display("Simulation FAILED");
        $fatal(1, "Timeout after %0d cycles without reaching the final jump", cycle_count);
      end else begin
        if (dmemory_valid && dmemory_ready) begin
          if (dmemory_wstrb == 4'b1111) begin
            if (exp_addr.size() == 0) begin
              $display("Simulation FAILED");
              $fatal(1, "Store to %08h at %0t was not expected by the model",
                     dmemory_addr, $time);
            end else begin
              check_value("dmemory_addr", dmemory_addr, exp_addr.pop_front());
              check_value("dmemory_wdata", dmemory_wdata, exp_data.pop_front());
            end
          end else begin
            // Loads carry no byte strobes
            check_value("dmemory_wstrb", 32'(dmemory_wstrb), 32'h0);
          end
        end
        if (imemory_valid && imemory_ready) begin
          check_value("imemory_addr", imemory_addr, model_pc);
          if (imemory_addr == halt_pc) begin
            halt_fetches++;
          end
          is_store = ref_step(st_addr, st_data);
          if (is_store) begin
            exp_addr.push_back(st_addr);
            exp_data.push_back(st_data);
          end
          if (halt_fetches == 2) begin
            if (exp_addr.size() == 0) begin
              $display("Simulation PASSED");
              $finish;
            end else begin
              $display("Simulation FAILED");
              $fatal(1, "Program ended with %0d stores never seen", exp_addr.size());
            end
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== cpu.f ====
rtl/cpu_pkg.sv
rtl/decoder.sv
rtl/alu.sv
rtl/register.sv
rtl/control_unit.sv
rtl/cpu.sv
verif/cpu_asserts.sv
verif/cpu_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := cpu_tb
FILELIST   := cpu.f
BUILD_DIR  := obj_dir
VFLAGS     := --binary --timing --assert -j 0 --Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
